//--- Makefile
TOP := tb_fetch

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module fetch_top
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f sources.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- core_defines.svh
// Width and memory sizing for the fetch front end
// IMEM_GNT_WAIT must be at least 1, the memory grants from a registered count
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data and address width
`define XLEN 32

// Word address bits of the instruction memory (256 words)
`define IMEM_AW 8

// Cycles between the first req cycle and the grant
`define IMEM_GNT_WAIT 1

`endif

//--- core_pkg.sv
// Pipeline control types shared by the fetch stage and its top level
// Encoding order matters to the decode stage, keep PC_SEQ at zero
`default_nettype none

package core_pkg;

    // Source of the next PC as reported by decode and execute
    typedef enum logic [1:0] {
        PC_SEQ    = 2'b00,
        PC_JAL    = 2'b01,
        PC_JALR   = 2'b10,
        PC_BRANCH = 2'b11
    } pc_source_t;

endpackage

`default_nettype wire

//--- fetch_top.sv
// Fetch stage joined to its instruction memory
// Decode, execute and CSR behavior is driven from outside through the redirect inputs
`default_nettype none
`timescale 1ns/100ps

`include "core_defines.svh"

module fetch_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic [`XLEN-3:0]     boot_addr_i,
    input  logic                 stall_if_i,
    // Redirect sources
    input  logic                 valid_id_i,
    input  logic                 valid_ex_i,
    input  logic [`XLEN-1:0]     jump_target_id_i,
    input  logic [`XLEN-1:0]     branch_target_ex_i,
    input  logic                 branch_decision_ex_i,
    input  core_pkg::pc_source_t pc_source_id_i,
    input  core_pkg::pc_source_t pc_source_ex_i,
    input  logic                 trap_id_i,
    input  logic                 trap_ex_i,
    input  logic                 is_mret_i,
    input  logic [`XLEN-1:0]     mtvec_i,
    input  logic [`XLEN-1:0]     mepc_i,
    // Memory load port
    input  logic                 load_we_i,
    input  logic [`IMEM_AW-1:0]  load_addr_i,
    input  logic [`XLEN-1:0]     load_data_i,
    // Toward decode
    output logic [`XLEN-1:0]     pc_if_o,
    output logic [`XLEN-1:0]     instr_if_o,
    output logic                 valid_if_o,
    output logic                 is_compressed_if_o
);
    // Instruction bus
    logic             obi_req;
    logic             obi_gnt;
    logic [`XLEN-1:0] obi_addr;
    logic             obi_we;
    logic [3:0]       obi_be;
    logic [`XLEN-1:0] obi_wdata;
    logic             obi_rvalid;
    logic             obi_rready;
    logic [`XLEN-1:0] obi_rdata;

    if_stage u_if_stage (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .boot_addr_i          (boot_addr_i),
        .stall_if_i           (stall_if_i),
        .valid_id_i           (valid_id_i),
        .valid_ex_i           (valid_ex_i),
        .jump_target_id_i     (jump_target_id_i),
        .branch_target_ex_i   (branch_target_ex_i),
        .branch_decision_ex_i (branch_decision_ex_i),
        .pc_source_id_i       (pc_source_id_i),
        .pc_source_ex_i       (pc_source_ex_i),
        .trap_id_i            (trap_id_i),
        .trap_ex_i            (trap_ex_i),
        .is_mret_i            (is_mret_i),
        .mtvec_i              (mtvec_i),
        .mepc_i               (mepc_i),
        .obi_req_o            (obi_req),
        .obi_gnt_i            (obi_gnt),
        .obi_addr_o           (obi_addr),
        .obi_we_o             (obi_we),
        .obi_be_o             (obi_be),
        .obi_wdata_o          (obi_wdata),
        .obi_rvalid_i         (obi_rvalid),
        .obi_rready_o         (obi_rready),
        .obi_rdata_i          (obi_rdata),
        .pc_if_o              (pc_if_o),
        .instr_if_o           (instr_if_o),
        .valid_if_o           (valid_if_o),
        .is_compressed_if_o   (is_compressed_if_o)
    );

    instr_sram u_instr_sram (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .obi_req_i    (obi_req),
        .obi_gnt_o    (obi_gnt),
        .obi_addr_i   (obi_addr),
        .obi_we_i     (obi_we),
        .obi_be_i     (obi_be),
        .obi_wdata_i  (obi_wdata),
        .obi_rvalid_o (obi_rvalid),
        .obi_rready_i (obi_rready),
        .obi_rdata_o  (obi_rdata),
        .load_we_i    (load_we_i),
        .load_addr_i  (load_addr_i),
        .load_data_i  (load_data_i)
    );

endmodule

`default_nettype wire

//--- if_stage.sv
// Fetch stage with a single outstanding fetch
// 32-bit instructions must be word aligned, a halfword PC only holds a compressed one
// Responses of fetches overtaken by a redirect are dropped on arrival
`default_nettype none
`timescale 1ns/100ps

`include "core_defines.svh"

module if_stage (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic [`XLEN-3:0]     boot_addr_i,
    input  logic                 stall_if_i,
    // Redirect sources
    input  logic                 valid_id_i,
    input  logic                 valid_ex_i,
    input  logic [`XLEN-1:0]     jump_target_id_i,
    input  logic [`XLEN-1:0]     branch_target_ex_i,
    input  logic                 branch_decision_ex_i,
    input  core_pkg::pc_source_t pc_source_id_i,
    input  core_pkg::pc_source_t pc_source_ex_i,
    input  logic                 trap_id_i,
    input  logic                 trap_ex_i,
    input  logic                 is_mret_i,
    input  logic [`XLEN-1:0]     mtvec_i,
    input  logic [`XLEN-1:0]     mepc_i,
    // OBI master
    output logic                 obi_req_o,
    input  logic                 obi_gnt_i,
    output logic [`XLEN-1:0]     obi_addr_o,
    output logic                 obi_we_o,
    output logic [3:0]           obi_be_o,
    output logic [`XLEN-1:0]     obi_wdata_o,
    input  logic                 obi_rvalid_i,
    output logic                 obi_rready_o,
    input  logic [`XLEN-1:0]     obi_rdata_i,
    // Toward decode
    output logic [`XLEN-1:0]     pc_if_o,
    output logic [`XLEN-1:0]     instr_if_o,
    output logic                 valid_if_o,
    output logic                 is_compressed_if_o
);
    logic [`XLEN-1:0] pc_q;        // PC of the fetch to issue or in progress
    logic             fetch_q;     // pc_q still has to be requested
    logic             gnt_wait_q;  // Request out, no grant yet
    logic             inflight_q;  // Granted, no response yet
    logic             stale_q;     // Outstanding fetch belongs to an old path
    logic             valid_q;
    logic [`XLEN-1:0] out_pc_q;
    logic [`XLEN-1:0] out_word_q;
    logic [`XLEN-1:0] next_pc;
    logic             redirect;
    logic             busy;
    logic             consume;
    logic             accept;
    logic             core_valid;
    logic             core_ready;
    logic             resp_valid;
    logic [`XLEN-1:0] resp_rdata;

    assign busy       = gnt_wait_q || inflight_q;
    assign core_valid = fetch_q && !busy;
    assign consume    = valid_q && !stall_if_i;
    // A redirect in the arrival cycle kills the response too
    assign accept     = resp_valid && !stale_q && !redirect;

    ////////////////////////////////////////
    // Fetch sequencing
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q       <= {boot_addr_i, 2'b00};
            fetch_q    <= 1'b1;
            gnt_wait_q <= 1'b0;
            inflight_q <= 1'b0;
            stale_q    <= 1'b0;
            valid_q    <= 1'b0;
        end else begin
            if (core_valid) begin
                fetch_q    <= 1'b0;
                gnt_wait_q <= !core_ready;
            end else if (core_ready) begin
                gnt_wait_q <= 1'b0;
            end

            if (core_ready) begin
                inflight_q <= 1'b1;
            end else if (resp_valid) begin
                inflight_q <= 1'b0;
            end

            // Anything on the bus at redirect time is from the old path
            if (redirect && ((busy && !resp_valid) || core_valid)) begin
                stale_q <= 1'b1;
            end else if (resp_valid) begin
                stale_q <= 1'b0;
            end

            if (accept) begin
                valid_q <= 1'b1;
            end

            // Next PC needs the compressed flag, so it is taken only here
            if (redirect || consume) begin
                pc_q    <= next_pc;
                fetch_q <= 1'b1;
                valid_q <= 1'b0;
            end
        end
    end

    // Output payload toward decode
    always_ff @(posedge clk_i) begin
        if (accept) begin
            out_pc_q   <= pc_q;
            out_word_q <= resp_rdata;
        end
    end

    assign pc_if_o    = out_pc_q;
    assign valid_if_o = valid_q;

    // Upper halfword at PC bit 1, zero-extended
    assign instr_if_o = out_pc_q[1] ? {{(`XLEN/2){1'b0}}, out_word_q[`XLEN-1:`XLEN/2]}
                                    : out_word_q;
    assign is_compressed_if_o = ~(instr_if_o[1] & instr_if_o[0]);

    ////////////////////////////////////////
    // Submodules
    ////////////////////////////////////////
    pc_controller u_pc_controller (
        .curr_pc_i            (out_pc_q),
        .is_compressed_if_i   (is_compressed_if_o),
        .valid_id_i           (valid_id_i),
        .valid_ex_i           (valid_ex_i),
        .jump_target_id_i     (jump_target_id_i),
        .branch_target_ex_i   (branch_target_ex_i),
        .branch_decision_ex_i (branch_decision_ex_i),
        .pc_source_id_i       (pc_source_id_i),
        .pc_source_ex_i       (pc_source_ex_i),
        .trap_id_i            (trap_id_i),
        .trap_ex_i            (trap_ex_i),
        .is_mret_i            (is_mret_i),
        .mtvec_i              (mtvec_i),
        .mepc_i               (mepc_i),
        .next_pc_o            (next_pc),
        .redirect_o           (redirect)
    );

    obi_controller u_obi_controller (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .core_valid_i (core_valid),
        .core_addr_i  ({pc_q[`XLEN-1:2], 2'b00}),
        .core_ready_o (core_ready),
        .resp_valid_o (resp_valid),
        .resp_rdata_o (resp_rdata),
        .obi_req_o    (obi_req_o),
        .obi_gnt_i    (obi_gnt_i),
        .obi_addr_o   (obi_addr_o),
        .obi_we_o     (obi_we_o),
        .obi_be_o     (obi_be_o),
        .obi_wdata_o  (obi_wdata_o),
        .obi_rvalid_i (obi_rvalid_i),
        .obi_rready_o (obi_rready_o),
        .obi_rdata_i  (obi_rdata_i)
    );

endmodule

`default_nettype wire

//--- instr_sram.sv
// OBI read-only word memory, filled through the load port during reset
// Grant comes IMEM_GNT_WAIT cycles after req, which must be 1 or more
`default_nettype none
`timescale 1ns/100ps

`include "core_defines.svh"

module instr_sram (
    input  logic               clk_i,
    input  logic               rst_n_i,
    // OBI slave
    input  logic               obi_req_i,
    output logic               obi_gnt_o,
    input  logic [`XLEN-1:0]   obi_addr_i,
    input  logic               obi_we_i,
    input  logic [3:0]         obi_be_i,
    input  logic [`XLEN-1:0]   obi_wdata_i,
    output logic               obi_rvalid_o,
    input  logic               obi_rready_i,
    output logic [`XLEN-1:0]   obi_rdata_o,
    // Load port
    input  logic               load_we_i,
    input  logic [`IMEM_AW-1:0] load_addr_i,
    input  logic [`XLEN-1:0]   load_data_i
);
    import obi_pkg::*;

    localparam int CW = (`IMEM_GNT_WAIT > 1) ? $clog2(`IMEM_GNT_WAIT) : 1;

    logic [`XLEN-1:0] mem [2**`IMEM_AW];
    obi_state_t       state_q;
    logic [CW-1:0]    cnt_q;    // Cycles left before the grant
    logic [`XLEN-1:0] rdata_q;

    // Grant from registered state only
    assign obi_gnt_o    = (state_q == OBI_REQ) && (cnt_q == '0);
    assign obi_rvalid_o = (state_q == OBI_RESP);
    assign obi_rdata_o  = rdata_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= OBI_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                OBI_IDLE: begin
                    if (obi_req_i) begin
                        state_q <= OBI_REQ;
                        cnt_q   <= CW'(`IMEM_GNT_WAIT - 1);
                    end
                end
                OBI_REQ: begin
                    if (obi_gnt_o) begin
                        state_q <= OBI_RESP;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                // Response stays up until the master takes it
                OBI_RESP: begin
                    if (obi_rready_i) begin
                        state_q <= OBI_IDLE;
                    end
                end
                default: state_q <= OBI_IDLE;
            endcase
        end
    end

    // Storage and read data, no reset
    always_ff @(posedge clk_i) begin
        if (load_we_i) begin
            mem[load_addr_i] <= load_data_i;
        end
        if (obi_gnt_o) begin
            rdata_q <= mem[obi_addr_i[`IMEM_AW+1:2]];
        end
    end

    ////////////////////////////////////////
    // Slave side checks
    ////////////////////////////////////////

    // Master has to keep req up through the whole wait
    a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        obi_gnt_o |-> obi_req_i);

    // Only full-word reads reach this memory
    a_read_only: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        obi_req_i |-> !obi_we_i && (obi_be_i == 4'b1111) && (obi_wdata_i == '0));

endmodule

`default_nettype wire

//--- obi_controller.sv
// OBI read master, one transfer at a time, no error or atomic support
// core_valid_i is a pulse accepted in the idle state only
`default_nettype none
`timescale 1ns/100ps

`include "core_defines.svh"

module obi_controller (
    input  logic             clk_i,
    input  logic             rst_n_i,
    // Core side
    input  logic             core_valid_i,
    input  logic [`XLEN-1:0] core_addr_i,
    output logic             core_ready_o,
    output logic             resp_valid_o,
    output logic [`XLEN-1:0] resp_rdata_o,
    // OBI bus
    output logic             obi_req_o,
    input  logic             obi_gnt_i,
    output logic [`XLEN-1:0] obi_addr_o,
    output logic             obi_we_o,
    output logic [3:0]       obi_be_o,
    output logic [`XLEN-1:0] obi_wdata_o,
    input  logic             obi_rvalid_i,
    output logic             obi_rready_o,
    input  logic [`XLEN-1:0] obi_rdata_i
);
    import obi_pkg::*;

    obi_state_t       state_q;
    logic [`XLEN-1:0] addr_q;

    // In idle the request goes straight out, later from the latched address
    assign obi_req_o  = ((state_q == OBI_IDLE) && core_valid_i) || (state_q == OBI_REQ);
    assign obi_addr_o = (state_q == OBI_IDLE) ? core_addr_i : addr_q;

    // Read-only master with full-word transfers
    assign obi_we_o    = 1'b0;
    assign obi_be_o    = 4'b1111;
    assign obi_wdata_o = '0;

    assign obi_rready_o = (state_q == OBI_RESP);
    assign core_ready_o = obi_req_o && obi_gnt_i;

    // Response passes through in the cycle rvalid is seen
    assign resp_valid_o = (state_q == OBI_RESP) && obi_rvalid_i;
    assign resp_rdata_o = obi_rdata_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= OBI_IDLE;
        end else begin
            case (state_q)
                OBI_IDLE: begin
                    if (core_valid_i) begin
                        state_q <= obi_gnt_i ? OBI_RESP : OBI_REQ;
                    end
                end
                OBI_REQ: begin
                    if (obi_gnt_i) begin
                        state_q <= OBI_RESP;
                    end
                end
                OBI_RESP: begin
                    if (obi_rvalid_i) begin
                        state_q <= OBI_IDLE;
                    end
                end
                default: state_q <= OBI_IDLE;
            endcase
        end
    end

    // Address capture, payload only
    always_ff @(posedge clk_i) begin
        if ((state_q == OBI_IDLE) && core_valid_i) begin
            addr_q <= core_addr_i;
        end
    end

    ////////////////////////////////////////
    // Bus protocol checks
    ////////////////////////////////////////

    // Address phase may not be withdrawn or changed before the slave grants
    a_req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        obi_req_o && !obi_gnt_i |=> obi_req_o && $stable(obi_addr_o));

    // Slave must not answer a transfer that was never granted
    a_no_idle_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_q == OBI_IDLE) |-> !obi_rvalid_i);

endmodule

`default_nettype wire

//--- obi_pkg.sv
// OBI transfer states shared by the bus master and the memory slave
`default_nettype none

package obi_pkg;

    // Idle, address phase waiting for gnt, response phase waiting for rvalid
    typedef enum logic [1:0] {
        OBI_IDLE = 2'b00,
        OBI_REQ  = 2'b01,
        OBI_RESP = 2'b10
    } obi_state_t;

endpackage

`default_nettype wire

//--- pc_controller.sv
// Next-PC selection, purely combinational
// Redirect inputs are single-cycle pulses, traps win over everything else
`default_nettype none
`timescale 1ns/100ps

`include "core_defines.svh"

module pc_controller (
    input  logic [`XLEN-1:0]     curr_pc_i,
    input  logic                 is_compressed_if_i,
    input  logic                 valid_id_i,
    input  logic                 valid_ex_i,
    input  logic [`XLEN-1:0]     jump_target_id_i,
    input  logic [`XLEN-1:0]     branch_target_ex_i,
    input  logic                 branch_decision_ex_i,
    input  core_pkg::pc_source_t pc_source_id_i,
    input  core_pkg::pc_source_t pc_source_ex_i,
    input  logic                 trap_id_i,
    input  logic                 trap_ex_i,
    input  logic                 is_mret_i,
    input  logic [`XLEN-1:0]     mtvec_i,
    input  logic [`XLEN-1:0]     mepc_i,
    output logic [`XLEN-1:0]     next_pc_o,
    output logic                 redirect_o
);
    import core_pkg::*;

    logic             branch_taken;
    logic             jump_taken;
    logic [`XLEN-1:0] seq_pc;

    // Only a resolved branch in EX counts, a not-taken one falls through
    assign branch_taken = valid_ex_i && branch_decision_ex_i && (pc_source_ex_i == PC_BRANCH);

    // Jumps are known in ID already
    assign jump_taken = valid_id_i && ((pc_source_id_i == PC_JAL) || (pc_source_id_i == PC_JALR));

    // Sequential step follows the size of the instruction just delivered
    assign seq_pc = curr_pc_i + (is_compressed_if_i ? `XLEN'd2 : `XLEN'd4);

    ////////////////////////////////////////
    // Priority mux
    ////////////////////////////////////////
    always_comb begin
        next_pc_o  = seq_pc;
        redirect_o = 1'b1;
        if (trap_ex_i || trap_id_i) begin
            next_pc_o = mtvec_i;
        end else if (is_mret_i) begin
            next_pc_o = mepc_i;
        end else if (branch_taken) begin
            // Older instruction in EX beats the jump in ID
            next_pc_o = branch_target_ex_i;
        end else if (jump_taken) begin
            next_pc_o = jump_target_id_i;
        end else begin
            redirect_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
core_pkg.sv
obi_pkg.sv
pc_controller.sv
obi_controller.sv
if_stage.sv
instr_sram.sv
fetch_top.sv
tb_fetch.sv

//--- tb_fetch.sv
// Directed testbench for the fetch front end with a reference PC and halfword model
// Memory image is loaded through the load port while reset is held
// Stall patterns come from a 16-bit LFSR seeded with 15
`default_nettype none
`timescale 1ns/100ps

`include "core_defines.svh"

module tb_fetch;
    import core_pkg::*;

    localparam int WAIT_LIMIT = 50;

    logic                clk;
    logic                rst_n;
    logic [`XLEN-3:0]    boot_addr;
    logic                stall_if;
    logic                valid_id;
    logic                valid_ex;
    logic [`XLEN-1:0]    jump_target_id;
    logic [`XLEN-1:0]    branch_target_ex;
    logic                branch_decision;
    pc_source_t          pc_source_id;
    pc_source_t          pc_source_ex;
    logic                trap_id;
    logic                trap_ex;
    logic                is_mret;
    logic [`XLEN-1:0]    mtvec;
    logic [`XLEN-1:0]    mepc;
    logic                load_we;
    logic [`IMEM_AW-1:0] load_addr;
    logic [`XLEN-1:0]    load_data;
    logic [`XLEN-1:0]    pc_if;
    logic [`XLEN-1:0]    instr_if;
    logic                valid_if;
    logic                is_compressed_if;

    // Testbench copy of the memory contents
    logic [`XLEN-1:0] img [2**`IMEM_AW];
    logic [15:0]      lfsr;
    int               test_errors;
    int               total_errors;
    int               tests_run;
    int               tests_failed;

    fetch_top DUT (
        .clk_i                (clk),
        .rst_n_i              (rst_n),
        .boot_addr_i          (boot_addr),
        .stall_if_i           (stall_if),
        .valid_id_i           (valid_id),
        .valid_ex_i           (valid_ex),
        .jump_target_id_i     (jump_target_id),
        .branch_target_ex_i   (branch_target_ex),
        .branch_decision_ex_i (branch_decision),
        .pc_source_id_i       (pc_source_id),
        .pc_source_ex_i       (pc_source_ex),
        .trap_id_i            (trap_id),
        .trap_ex_i            (trap_ex),
        .is_mret_i            (is_mret),
        .mtvec_i              (mtvec),
        .mepc_i               (mepc),
        .load_we_i            (load_we),
        .load_addr_i          (load_addr),
        .load_data_i          (load_data),
        .pc_if_o              (pc_if),
        .instr_if_o           (instr_if),
        .valid_if_o           (valid_if),
        .is_compressed_if_o   (is_compressed_if)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Even words 0x40 to 0x4E hold two compressed halves
    // All other words hold one 32-bit op
    function automatic logic [`XLEN-1:0] fill_word(input logic [7:0] a);
        if ((a[7:4] == 4'h4) && !a[0]) begin
            fill_word = {a, 6'h15, 2'b10, ~a, 6'h2A, 2'b01};
        end else begin
            fill_word = {8'hA5 ^ a, a, 8'h3C ^ a, a[5:0], 2'b11};
        end
    endfunction

    // Upper halfword zero-extended when PC bit 1 is set
    function automatic logic [`XLEN-1:0] ref_instr(input logic [`XLEN-1:0] pc);
        logic [`XLEN-1:0] w;
        w = img[pc[`IMEM_AW+1:2]];
        ref_instr = pc[1] ? {16'h0000, w[31:16]} : w;
    endfunction

    function automatic logic [`XLEN-1:0] ref_next_pc(input logic [`XLEN-1:0] pc);
        logic [`XLEN-1:0] ins;
        ins = ref_instr(pc);
        ref_next_pc = (ins[1:0] == 2'b11) ? pc + 32'd4 : pc + 32'd2;
    endfunction

    // Taps x^16 + x^14 + x^13 + x^11 + 1 with one step per bit
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        lfsr_step = fb;
    endfunction

    ////////////////////////////////////////
    // Drivers and checkers
    ////////////////////////////////////////
    task automatic load_memory();
        for (int a = 0; a < 2**`IMEM_AW; a++) begin
            @(posedge clk);
            load_we   <= 1'b1;
            load_addr <= a[`IMEM_AW-1:0];
            load_data <= img[a];
        end
        @(posedge clk);
        load_we <= 1'b0;
    endtask

    task automatic apply_reset(input logic [`XLEN-3:0] boot);
        @(posedge clk);
        rst_n     <= 1'b0;
        boot_addr <= boot;
        stall_if  <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // One-cycle pulse on the redirect inputs
    // Jump and branch share one target
    task automatic pulse_redirect(input logic jump, input pc_source_t jump_src,
                                  input logic branch, input logic taken,
                                  input logic trap_d, input logic trap_e,
                                  input logic mret, input logic [`XLEN-1:0] target);
        @(posedge clk);
        valid_id         <= jump;
        pc_source_id     <= jump ? jump_src : PC_SEQ;
        jump_target_id   <= target;
        valid_ex         <= branch;
        pc_source_ex     <= branch ? PC_BRANCH : PC_SEQ;
        branch_decision  <= taken;
        branch_target_ex <= target;
        trap_id          <= trap_d;
        trap_ex          <= trap_e;
        is_mret          <= mret;
        @(posedge clk);
        valid_id        <= 1'b0;
        pc_source_id    <= PC_SEQ;
        valid_ex        <= 1'b0;
        pc_source_ex    <= PC_SEQ;
        branch_decision <= 1'b0;
        trap_id         <= 1'b0;
        trap_ex         <= 1'b0;
        is_mret         <= 1'b0;
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input logic [`XLEN-1:0] exp, input logic [`XLEN-1:0] act);
        $display("error %s: %s expected %h actual %h", name, what, exp, act);
        test_errors++;
    endtask

    // Polls each falling edge until valid_if_o rises or the limit runs out
    task automatic wait_valid(input string name, output logic ok);
        int n;
        ok = 1'b0;
        n = 0;
        while (!ok && (n < WAIT_LIMIT)) begin
            @(negedge clk);
            n++;
            if (valid_if === 1'b1) begin
                ok = 1'b1;
            end
        end
        if (!ok) begin
            $display("%s: no valid instruction came out within %0d cycles", name, WAIT_LIMIT);
            test_errors++;
        end
    endtask

    task automatic check_output(input string name, input logic [`XLEN-1:0] exp_pc);
        logic [`XLEN-1:0] exp_instr;
        logic             exp_c;
        exp_instr = ref_instr(exp_pc);
        exp_c     = (exp_instr[1:0] != 2'b11);
        if (pc_if !== exp_pc) begin
            report_mismatch(name, "pc", exp_pc, pc_if);
        end
        if (instr_if !== exp_instr) begin
            report_mismatch(name, "instr", exp_instr, instr_if);
        end
        if (is_compressed_if !== exp_c) begin
            report_mismatch(name, "compressed", {31'd0, exp_c}, {31'd0, is_compressed_if});
        end
    endtask

    task automatic expect_fetch(input string name, input logic [`XLEN-1:0] exp_pc);
        logic ok;
        wait_valid(name, ok);
        if (ok) begin
            check_output(name, exp_pc);
        end
    endtask

    task automatic begin_test();
        test_errors = 0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        total_errors += test_errors;
        $display("%s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "FAILED", test_errors);
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    task automatic test_boot();
        begin_test();
        apply_reset(30'h10);
        @(negedge clk);
        if (valid_if !== 1'b0) begin
            report_mismatch("boot", "valid_if_o", 32'd0, {31'd0, valid_if});
        end
        expect_fetch("boot", 32'h40);
        end_test("boot");
    endtask

    task automatic test_stream32();
        logic [`XLEN-1:0] pc;
        begin_test();
        apply_reset(30'h20);
        pc = 32'h80;
        repeat (8) begin
            expect_fetch("stream32", pc);
            pc = ref_next_pc(pc);
        end
        end_test("stream32");
    endtask

    // Compressed pairs followed by an aligned 32-bit op
    task automatic test_mixed();
        logic [`XLEN-1:0] pc;
        begin_test();
        apply_reset(30'h40);
        pc = 32'h100;
        repeat (12) begin
            expect_fetch("mixed", pc);
            pc = ref_next_pc(pc);
        end
        end_test("mixed");
    endtask

    task automatic test_stall();
        logic [`XLEN-1:0] pc;
        int               delivered;
        int               held;
        int               cycles;
        logic             was_held;
        begin_test();
        apply_reset(30'h44);
        pc        = 32'h110;
        delivered = 0;
        held      = 0;
        cycles    = 0;
        was_held  = 1'b0;
        while ((delivered < 12) && (cycles < 300)) begin
            @(posedge clk);
            stall_if <= lfsr_step();
            @(negedge clk);
            cycles++;
            // Output seen stalled last cycle has to be still there
            if (was_held && (valid_if !== 1'b1)) begin
                $display("stall: valid output dropped while stalled");
                test_errors++;
            end
            was_held = 1'b0;
            if (valid_if === 1'b1) begin
                check_output("stall", pc);
                // A held output must show the same PC again next cycle
                if (stall_if) begin
                    held++;
                    was_held = 1'b1;
                end else begin
                    delivered++;
                    pc = ref_next_pc(pc);
                end
            end
        end
        @(posedge clk);
        stall_if <= 1'b0;
        if (delivered < 12) begin
            $display("stall: only %0d of 12 instructions delivered", delivered);
            test_errors++;
        end
        if (held == 0) begin
            $display("stall: no stall cycle ever met a valid output");
            test_errors++;
        end
        end_test("stall");
    endtask

    task automatic test_redirect();
        begin_test();
        apply_reset(30'h20);
        expect_fetch("redirect", 32'h80);
        pulse_redirect(1'b1, PC_JAL, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h200);
        expect_fetch("redirect", 32'h200);
        pulse_redirect(1'b0, PC_SEQ, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 32'h300);
        expect_fetch("redirect", 32'h300);
        // Branch resolved as not taken
        pulse_redirect(1'b0, PC_SEQ, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 32'h3F0);
        expect_fetch("redirect", 32'h304);
        @(posedge clk);
        stall_if <= 1'b1;
        expect_fetch("redirect", 32'h308);
        // Jump while the output is held by a stall
        pulse_redirect(1'b1, PC_JALR, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h2A0);
        @(posedge clk);
        stall_if <= 1'b0;
        expect_fetch("redirect", 32'h2A0);
        end_test("redirect");
    endtask

    task automatic test_trap_mret();
        begin_test();
        apply_reset(30'h20);
        expect_fetch("trap_mret", 32'h80);
        pulse_redirect(1'b0, PC_SEQ, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 32'h0);
        expect_fetch("trap_mret", mtvec);
        // mepc points at the upper compressed half of word 0x40
        pulse_redirect(1'b0, PC_SEQ, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h0);
        expect_fetch("trap_mret", mepc);
        pulse_redirect(1'b1, PC_JAL, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 32'h200);
        expect_fetch("trap_mret", mtvec);
        expect_fetch("trap_mret", ref_next_pc(mtvec));
        end_test("trap_mret");
    endtask

    initial begin
        rst_n            = 1'b0;
        boot_addr        = '0;
        stall_if         = 1'b0;
        valid_id         = 1'b0;
        valid_ex         = 1'b0;
        jump_target_id   = '0;
        branch_target_ex = '0;
        branch_decision  = 1'b0;
        pc_source_id     = PC_SEQ;
        pc_source_ex     = PC_SEQ;
        trap_id          = 1'b0;
        trap_ex          = 1'b0;
        is_mret          = 1'b0;
        mtvec            = 32'h380;
        mepc             = 32'h102;
        load_we          = 1'b0;
        load_addr        = '0;
        load_data        = '0;
        lfsr             = 16'd15;
        total_errors     = 0;
        tests_run        = 0;
        tests_failed     = 0;
        for (int i = 0; i < 2**`IMEM_AW; i++) begin
            img[i] = fill_word(i[7:0]);
        end
        load_memory();

        test_boot();
        test_stream32();
        test_mixed();
        test_stall();
        test_redirect();
        test_trap_mret();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
